//--- source/rrv_defines.svh
`ifndef RRV_DEFINES_SVH
`define RRV_DEFINES_SVH

// ==============================
// memory sizes
// ==============================
`define RRV_IMEM_WORDS 1024            // 4 KB of instructions
`define RRV_DMEM_WORDS 1024            // 4 KB of data

// ==============================
// region bases, byte addresses
// ==============================
`define RRV_IMEM_BASE  32'h0000_0000
`define RRV_DMEM_BASE  32'h0000_1000
`define RRV_CR_BASE    32'h0000_2000   // led word then switch word

`define RRV_RF_NUM     16              // rv32e register count
`define RRV_RESET_PC   32'h0000_0000   // first fetch after RstPc

`endif

//--- source/rrv_pkg.sv
package rrv_pkg;

   // ==============================
   // datapath widths
   // ==============================
   typedef logic [31:0] tWord;      // data word
   typedef logic [31:0] tAddr;      // byte address
   typedef logic [3:0]  tRegIdx;    // x0..x15 only

   // fabric request kind
   typedef enum logic {
      FabRead  = 1'b0,
      FabWrite = 1'b1
   } tFabOp;

   // ==============================
   // core sequencing
   // ==============================
   typedef enum logic [1:0] {
      Fetch,                        // pc out to i_mem
      Execute,                      // decode and alu
      Memory,                       // lw/sw on the data port
      Writeback                     // rf update, pc step
   } tCoreState;

endpackage

//--- source/rrv_dpram.sv
`timescale 1ns/1ps

module rrv_dpram #(
   parameter int Words = 1024
) (
   input  logic          Clock,
   input  logic          aEn,
   input  logic          aWrEn,
   input  rrv_pkg::tAddr aAddr,      // byte offset into the region
   input  rrv_pkg::tWord aWrData,
   output rrv_pkg::tWord aRdData,
   input  logic          bEn,
   input  logic          bWrEn,
   input  rrv_pkg::tAddr bAddr,
   input  rrv_pkg::tWord bWrData,
   output rrv_pkg::tWord bRdData
);
   import rrv_pkg::*;

   localparam int IdxW = $clog2(Words);

   tWord mem [Words] = '{default: '0};   // unwritten words read as zero

   always_ff @(posedge Clock) begin
      if (aEn) begin
         if (aWrEn) begin
            mem[aAddr[IdxW+1:2]] <= aWrData;
         end
         aRdData <= mem[aAddr[IdxW+1:2]];   // old data on same-cycle write
      end
      if (bEn) begin
         if (bWrEn) begin
            mem[bAddr[IdxW+1:2]] <= bWrData;
         end
         bRdData <= mem[bAddr[IdxW+1:2]];
      end
   end

   aInRangeA: assert property (@(posedge Clock) aEn |-> (aAddr >> 2) < Words);
   aInRangeB: assert property (@(posedge Clock) bEn |-> (bAddr >> 2) < Words);

endmodule

//--- source/rrv_cr_regs.sv
`timescale 1ns/1ps

module rrv_cr_regs (
   input  logic          Clock,
   input  logic          arstN,
   input  logic [7:0]    fpgaIn,          // switches, async to Clock
   output logic [7:0]    fpgaOut,         // leds
   // core port
   input  logic          coreEn,
   input  logic          coreWrEn,
   input  rrv_pkg::tAddr coreAddr,
   input  rrv_pkg::tWord coreWrData,
   output rrv_pkg::tWord coreRdData,
   output logic          coreGrant,       // becomes dMemReady
   // fabric port
   input  logic          fabEn,
   input  logic          fabWrEn,
   input  rrv_pkg::tAddr fabAddr,
   input  rrv_pkg::tWord fabWrData,
   output rrv_pkg::tWord fabRdData
);
   import rrv_pkg::*;

   logic [7:0] ledQ;
   logic [7:0] swMetaQ;
   logic [7:0] swSyncQ;
   logic       coreHit;
   tWord       ledWord;
   tWord       swWord;

   // ==============================
   // fabric first, core retries
   // ==============================
   assign coreGrant = !(coreEn && fabEn);
   assign coreHit   = coreEn && coreGrant;

   assign ledWord = {24'b0, ledQ};
   assign swWord  = {24'b0, swSyncQ};
   assign fpgaOut = ledQ;

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         ledQ    <= '0;
         swMetaQ <= '0;
         swSyncQ <= '0;
      end else begin
         swMetaQ <= fpgaIn;               // two-flop sync
         swSyncQ <= swMetaQ;
         if (fabEn && fabWrEn && !fabAddr[2]) begin
            ledQ <= fabWrData[7:0];
         end else if (coreHit && coreWrEn && !coreAddr[2]) begin
            ledQ <= coreWrData[7:0];
         end
      end
   end

   // registered reads, same latency as the rams
   always_ff @(posedge Clock) begin
      if (coreHit) begin
         coreRdData <= coreAddr[2] ? swWord : ledWord;
      end
      if (fabEn) begin
         fabRdData <= fabAddr[2] ? swWord : ledWord;   // switch reg is read-only
      end
   end

endmodule

//--- source/core_rrv.sv
`timescale 1ns/1ps
`include "rrv_defines.svh"

module core_rrv (
   input  logic          Clock,
   input  logic          arstN,
   input  logic          RstPc,                // park at reset pc
   // instruction side
   output rrv_pkg::tAddr pcQ100H,
   output logic          readyQ101H,           // fetch strobe
   input  rrv_pkg::tWord preInstructionQ101H,
   // data side
   output rrv_pkg::tAddr dMemAddressQ103H,
   output rrv_pkg::tWord dMemWrDataQ103H,
   output logic          dMemWrEnQ103H,
   output logic          dMemRdEnQ103H,
   input  rrv_pkg::tWord dMemRdRspQ105H,
   input  logic          dMemReady             // low on cr collision
);
   import rrv_pkg::*;

   // ==============================
   // opcodes
   // ==============================
   localparam logic [6:0] OpImm    = 7'b0010011;
   localparam logic [6:0] OpReg    = 7'b0110011;
   localparam logic [6:0] OpLui    = 7'b0110111;
   localparam logic [6:0] OpLoad   = 7'b0000011;
   localparam logic [6:0] OpStore  = 7'b0100011;
   localparam logic [6:0] OpBranch = 7'b1100011;
   localparam logic [6:0] OpJal    = 7'b1101111;

   tCoreState state;
   tWord      rf [`RRV_RF_NUM] = '{default: '0};   // x0 never written

   // execute to writeback
   tWord   resultQ;                 // alu result or load/store address
   tWord   storeDataQ;
   tAddr   nextPcQ;
   tRegIdx rdQ;
   logic   wbEnQ;
   logic   isLoadQ;
   logic   isStoreQ;

   // decode
   tWord       instr;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [2:0] aluF3;
   tRegIdx     rs1;
   tRegIdx     rs2;
   tRegIdx     rd;
   tWord       rs1Val;
   tWord       rs2Val;
   tWord       immI;
   tWord       immS;
   tWord       immB;
   tWord       immJ;
   tWord       immU;
   tWord       aluB;
   tWord       aluOut;
   tWord       resultD;
   tAddr       nextPcD;
   logic       isOpImm;
   logic       isOp;
   logic       isLui;
   logic       isLoad;
   logic       isStore;
   logic       isBranch;
   logic       isJal;
   logic       takeBranch;
   logic       wbEnD;

   assign instr  = preInstructionQ101H;      // valid during Execute only
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign rd     = instr[10:7];              // upper index bit dropped, rv32e
   assign rs1    = instr[18:15];
   assign rs2    = instr[23:20];
   assign rs1Val = rf[rs1];
   assign rs2Val = rf[rs2];

   assign isOpImm  = opcode == OpImm;
   assign isOp     = opcode == OpReg;
   assign isLui    = opcode == OpLui;
   assign isLoad   = opcode == OpLoad;
   assign isStore  = opcode == OpStore;
   assign isBranch = opcode == OpBranch;
   assign isJal    = opcode == OpJal;
   assign wbEnD    = isOpImm || isOp || isLui || isLoad || isJal;   // unknown op is a no-op

   // ==============================
   // immediates
   // ==============================
   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
   assign immU = {instr[31:12], 12'b0};

   always_comb begin
      aluB  = isOp ? rs2Val : (isStore ? immS : immI);
      aluF3 = (isOp || isOpImm) ? funct3 : 3'b000;   // ld/st need the add
      case (aluF3)
         3'b100:  aluOut = rs1Val ^ aluB;
         3'b110:  aluOut = rs1Val | aluB;
         3'b111:  aluOut = rs1Val & aluB;
         default: aluOut = (isOp && instr[30]) ? rs1Val - aluB : rs1Val + aluB;
      endcase
   end

   // beq on 000, bne on 001, other branch kinds fall through
   assign takeBranch = isBranch && ((funct3 == 3'b000 && rs1Val == rs2Val) ||
                                    (funct3 == 3'b001 && rs1Val != rs2Val));

   assign resultD = isLui ? immU : (isJal ? pcQ100H + 32'd4 : aluOut);   // jal links pc+4
   assign nextPcD = isJal      ? pcQ100H + immJ :
                    takeBranch ? pcQ100H + immB :
                                 pcQ100H + 32'd4;

   // ==============================
   // state machine
   // ==============================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         state   <= Fetch;
         pcQ100H <= `RRV_RESET_PC;
      end else if (RstPc) begin
         state   <= Fetch;                          // loading phase
         pcQ100H <= `RRV_RESET_PC;
      end else begin
         case (state)
            Fetch:   state <= Execute;              // instr arrives next cycle
            Execute: state <= (isLoad || isStore) ? Memory : Writeback;
            Memory: begin
               if (dMemReady) begin
                  state <= Writeback;               // else retry the access
               end
            end
            default: begin
               pcQ100H <= nextPcQ;
               state   <= Fetch;
            end
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (state == Execute) begin
         resultQ    <= resultD;
         storeDataQ <= rs2Val;
         nextPcQ    <= nextPcD;
         rdQ        <= rd;
         wbEnQ      <= wbEnD;
         isLoadQ    <= isLoad;
         isStoreQ   <= isStore;
      end
      if (state == Writeback && !RstPc && wbEnQ && rdQ != '0) begin
         rf[rdQ] <= isLoadQ ? dMemRdRspQ105H : resultQ;   // load data lands now
      end
   end

   assign readyQ101H       = (state == Fetch) && !RstPc;
   assign dMemAddressQ103H = resultQ;
   assign dMemWrDataQ103H  = storeDataQ;
   assign dMemWrEnQ103H    = (state == Memory) && isStoreQ && !RstPc;
   assign dMemRdEnQ103H    = (state == Memory) && isLoadQ && !RstPc;

   aRdWrExcl: assert property (@(posedge Clock) disable iff (!arstN)
      !(dMemRdEnQ103H && dMemWrEnQ103H));
   aWordAlign: assert property (@(posedge Clock) disable iff (!arstN)
      (dMemRdEnQ103H || dMemWrEnQ103H) |-> dMemAddressQ103H[1:0] == 2'b00);

endmodule

//--- source/core_rrv_mem_wrap.sv
`timescale 1ns/1ps
`include "rrv_defines.svh"

module core_rrv_mem_wrap (
   input  logic           Clock,
   input  logic           arstN,
   // core side
   input  rrv_pkg::tAddr  pcQ100H,
   input  logic           readyQ101H,
   output rrv_pkg::tWord  preInstructionQ101H,
   input  rrv_pkg::tAddr  dMemAddressQ103H,
   input  rrv_pkg::tWord  dMemWrDataQ103H,
   input  logic           dMemWrEnQ103H,
   input  logic           dMemRdEnQ103H,
   output rrv_pkg::tWord  dMemRdRspQ105H,
   output logic           dMemReady,
   // fabric side
   input  logic           inFabricValidQ503H,
   input  rrv_pkg::tFabOp inFabricOpQ503H,
   input  rrv_pkg::tAddr  inFabricAddressQ503H,
   input  rrv_pkg::tWord  inFabricDataQ503H,
   output logic           coreRrvReady,
   output logic           outFabricValidQ505H,
   output rrv_pkg::tWord  outFabricDataQ505H,
   input  logic           fabReady,
   // board
   input  logic [7:0]     fpgaIn,
   output logic [7:0]     fpgaOut
);
   import rrv_pkg::*;

   localparam logic [1:0] RegImem = 2'd0;
   localparam logic [1:0] RegDmem = 2'd1;
   localparam logic [1:0] RegCr   = 2'd2;

   function automatic logic [1:0] regionOf(input tAddr addr);
      if (addr >= `RRV_CR_BASE) begin
         return RegCr;
      end else if (addr >= `RRV_DMEM_BASE) begin
         return RegDmem;
      end
      return RegImem;
   endfunction

   logic [1:0] coreRegion, fabRegion;
   logic [1:0] coreRegionQ104H;        // picks the core response
   logic [1:0] fabRegionQ504H;
   logic       coreDataEn, fabAccept, fabWr, fabStall, fabRdValidQ504H;
   tWord       dMemCoreRd, dMemFabRd, iMemFabRd, crCoreRd, crFabRd, fabRdDataQ504H;

   assign coreRegion   = regionOf(dMemAddressQ103H);
   assign fabRegion    = regionOf(inFabricAddressQ503H);
   assign coreDataEn   = dMemRdEnQ103H || dMemWrEnQ103H;
   assign fabWr        = inFabricOpQ503H == FabWrite;
   assign fabStall     = outFabricValidQ505H && !fabReady;   // response held
   assign coreRrvReady = !fabStall;
   assign fabAccept    = inFabricValidQ503H && coreRrvReady;

   // ==============================
   // memories
   // ==============================
   rrv_dpram #(.Words(`RRV_IMEM_WORDS)) iMem (
      .Clock(Clock),
      .aEn(readyQ101H), .aWrEn(1'b0), .aAddr(pcQ100H - `RRV_IMEM_BASE),   // fetch only
      .aWrData('0), .aRdData(preInstructionQ101H),
      .bEn(fabAccept && fabRegion == RegImem), .bWrEn(fabWr),
      .bAddr(inFabricAddressQ503H - `RRV_IMEM_BASE),
      .bWrData(inFabricDataQ503H), .bRdData(iMemFabRd)
   );

   rrv_dpram #(.Words(`RRV_DMEM_WORDS)) dMem (
      .Clock(Clock),
      .aEn(coreDataEn && coreRegion == RegDmem), .aWrEn(dMemWrEnQ103H),
      .aAddr(dMemAddressQ103H - `RRV_DMEM_BASE),
      .aWrData(dMemWrDataQ103H), .aRdData(dMemCoreRd),
      .bEn(fabAccept && fabRegion == RegDmem), .bWrEn(fabWr),
      .bAddr(inFabricAddressQ503H - `RRV_DMEM_BASE),
      .bWrData(inFabricDataQ503H), .bRdData(dMemFabRd)
   );

   rrv_cr_regs crRegs (
      .Clock(Clock), .arstN(arstN), .fpgaIn(fpgaIn), .fpgaOut(fpgaOut),
      .coreEn(coreDataEn && coreRegion == RegCr), .coreWrEn(dMemWrEnQ103H),
      .coreAddr(dMemAddressQ103H), .coreWrData(dMemWrDataQ103H),
      .coreRdData(crCoreRd), .coreGrant(dMemReady),   // fabric wins collisions
      .fabEn(fabAccept && fabRegion == RegCr), .fabWrEn(fabWr),
      .fabAddr(inFabricAddressQ503H), .fabWrData(inFabricDataQ503H), .fabRdData(crFabRd)
   );

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         coreRegionQ104H <= RegDmem;
      end else if (coreDataEn && dMemReady) begin
         coreRegionQ104H <= coreRegion;
      end
   end

   assign dMemRdRspQ105H = (coreRegionQ104H == RegCr) ? crCoreRd : dMemCoreRd;

   // ==============================
   // fabric Q503 -> Q505
   // ==============================
   always_comb begin
      case (fabRegionQ504H)
         RegImem: fabRdDataQ504H = iMemFabRd;
         RegDmem: fabRdDataQ504H = dMemFabRd;
         default: fabRdDataQ504H = crFabRd;
      endcase
   end

   // ram outputs hold while stalled, no port is enabled then
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         fabRdValidQ504H     <= 1'b0;
         fabRegionQ504H      <= RegImem;
         outFabricValidQ505H <= 1'b0;
      end else if (!fabStall) begin
         fabRdValidQ504H     <= fabAccept && !fabWr;   // writes get no response
         fabRegionQ504H      <= fabRegion;
         outFabricValidQ505H <= fabRdValidQ504H;
      end
   end

   always_ff @(posedge Clock) begin
      if (!fabStall && fabRdValidQ504H) begin
         outFabricDataQ505H <= fabRdDataQ504H;
      end
   end

endmodule

//--- source/core_rrv_top.sv
`timescale 1ns/1ps

module core_rrv_top (
   input  logic           Clock,
   input  logic           arstN,
   input  logic           RstPc,                 // high while loading
   // fabric request
   input  logic           inFabricValidQ503H,
   input  rrv_pkg::tFabOp inFabricOpQ503H,
   input  rrv_pkg::tAddr  inFabricAddressQ503H,
   input  rrv_pkg::tWord  inFabricDataQ503H,
   output logic           coreRrvReady,
   // fabric response
   output logic           outFabricValidQ505H,
   output rrv_pkg::tWord  outFabricDataQ505H,
   input  logic           fabReady,
   // board
   input  logic [7:0]     fpgaIn,                // switches
   output logic [7:0]     fpgaOut                // leds
);
   import rrv_pkg::*;

   // ==============================
   // core to memory wrapper
   // ==============================
   tAddr pcQ100H;
   logic readyQ101H;
   tWord preInstructionQ101H;
   tAddr dMemAddressQ103H;
   tWord dMemWrDataQ103H;
   logic dMemWrEnQ103H;
   logic dMemRdEnQ103H;
   tWord dMemRdRspQ105H;
   logic dMemReady;

   core_rrv coreRrv (
      .Clock(Clock), .arstN(arstN), .RstPc(RstPc),
      .pcQ100H(pcQ100H), .readyQ101H(readyQ101H), .preInstructionQ101H(preInstructionQ101H),
      .dMemAddressQ103H(dMemAddressQ103H), .dMemWrDataQ103H(dMemWrDataQ103H),
      .dMemWrEnQ103H(dMemWrEnQ103H), .dMemRdEnQ103H(dMemRdEnQ103H),
      .dMemRdRspQ105H(dMemRdRspQ105H), .dMemReady(dMemReady)
   );

   core_rrv_mem_wrap memWrap (
      .Clock(Clock), .arstN(arstN),
      .pcQ100H(pcQ100H), .readyQ101H(readyQ101H), .preInstructionQ101H(preInstructionQ101H),
      .dMemAddressQ103H(dMemAddressQ103H), .dMemWrDataQ103H(dMemWrDataQ103H),
      .dMemWrEnQ103H(dMemWrEnQ103H), .dMemRdEnQ103H(dMemRdEnQ103H),
      .dMemRdRspQ105H(dMemRdRspQ105H), .dMemReady(dMemReady),
      .inFabricValidQ503H(inFabricValidQ503H), .inFabricOpQ503H(inFabricOpQ503H),
      .inFabricAddressQ503H(inFabricAddressQ503H), .inFabricDataQ503H(inFabricDataQ503H),
      .coreRrvReady(coreRrvReady), .outFabricValidQ505H(outFabricValidQ505H),
      .outFabricDataQ505H(outFabricDataQ505H), .fabReady(fabReady),
      .fpgaIn(fpgaIn), .fpgaOut(fpgaOut)
   );

endmodule

//--- verif/tb_rrv_model.svh
`ifndef TB_RRV_MODEL_SVH
`define TB_RRV_MODEL_SVH

typedef enum int {KAddi, KAdd, KSub, KAnd, KOr, KXor, KLui, KLw, KSw, KBeq, KBne, KJal} tKind;

// ==============================
// reference model state
// ==============================
tKind       pKind [ProgLen];
tRegIdx     pRd [ProgLen] = '{default: '0};
tRegIdx     pRs1 [ProgLen] = '{default: '0};
tRegIdx     pRs2 [ProgLen] = '{default: '0};
tWord       pImm [ProgLen];                          // byte offset or full lui value
tWord       mRf [`RRV_RF_NUM];
tWord       dImg [`RRV_DMEM_WORDS] = '{default: '0};  // fabric data stays under the program
logic [7:0] mLed = 8'h00;                            // led reset value
tWord       expQ [$];                                // reads in flight, oldest first
int         acceptStepQ [$];                         // accept step of each read

function automatic int unsigned rnd(input int unsigned n);
   return $unsigned($random(seed)) % n;
endfunction

// rv32 field packing
function automatic tWord encode(input int k);
   tWord       i;
   tKind       kind;
   logic [2:0] f3;
   logic [6:0] f7;
   i    = pImm[k];
   kind = pKind[k];
   f3   = (kind == KAnd) ? 3'b111 : (kind == KOr) ? 3'b110 : (kind == KXor) ? 3'b100 : 3'b000;
   f7   = (kind == KSub) ? 7'b0100000 : 7'b0000000;
   case (kind)
      KAddi:   return {i[11:0], 1'b0, pRs1[k], 3'b000, 1'b0, pRd[k], 7'b0010011};
      KLui:    return {i[31:12], 1'b0, pRd[k], 7'b0110111};
      KLw:     return {i[11:0], 1'b0, pRs1[k], 3'b010, 1'b0, pRd[k], 7'b0000011};
      KSw:     return {i[11:5], 1'b0, pRs2[k], 1'b0, pRs1[k], 3'b010, i[4:0], 7'b0100011};
      KBeq, KBne: begin
         return {i[12], i[10:5], 1'b0, pRs2[k], 1'b0, pRs1[k], 2'b00, (kind == KBne),
                 i[4:1], i[11], 7'b1100011};
      end
      KJal:    return {i[20], i[10:1], i[11], i[19:12], 1'b0, pRd[k], 7'b1101111};
      default: return {f7, 1'b0, pRs2[k], 1'b0, pRs1[k], f3, 1'b0, pRd[k], 7'b0110011};
   endcase
endfunction

// ==============================
// program generator
// ==============================
task automatic genProgram();
   int unsigned pick;
   int unsigned left;
   tWord        r;
   pKind[0] = KLui;
   pRd[0]   = 4'd15;
   pImm[0]  = `RRV_DMEM_BASE;                  // x15 is the d_mem base
   pKind[1] = KLui;
   pRd[1]   = 4'd14;
   pImm[1]  = `RRV_CR_BASE;                    // x14 points at the led
   for (int k = 2; k < ProgLen - 1; k++) begin
      pick     = rnd(15);
      r        = $random(seed);
      left     = ProgLen - 1 - k;              // words up to the self-loop
      pKind[k] = (pick > 11) ? KSw : tKind'(pick);
      pRd[k]   = tRegIdx'(rnd(14));            // x0 included, bases kept
      pRs1[k]  = tRegIdx'(rnd(16));
      pRs2[k]  = tRegIdx'(rnd(16));
      case (pKind[k])
         KAddi:   pImm[k] = {{20{r[11]}}, r[11:0]};
         KLui:    pImm[k] = {r[19:0], 12'b0};
         KLw, KSw: begin
            pRs1[k] = 4'd15;
            pImm[k] = {24'b0, r[5:0], 2'b00};  // 64-word window
         end
         KBeq, KBne, KJal: pImm[k] = (1 + rnd((left < 4) ? left : 4)) * 4;   // forward only
         default: pImm[k] = '0;
      endcase
      if (pick == 12) begin
         pRs1[k] = 4'd14;                      // store to the led
         pImm[k] = '0;
      end
   end
   pKind[ProgLen-1] = KJal;                    // jal x0, 0
   pRd[ProgLen-1]   = 4'd0;
   pImm[ProgLen-1]  = '0;
endtask

// ==============================
// isa model
// ==============================
task automatic runModel();
   tWord pc;
   tWord a;
   int   k;
   pc  = `RRV_RESET_PC;
   mRf = '{default: '0};
   k   = 0;
   while (k != ProgLen - 1) begin
      a  = mRf[pRs1[k]] + pImm[k];             // ld/st address
      pc = pc + 32'd4;
      case (pKind[k])
         KAddi: mRf[pRd[k]] = mRf[pRs1[k]] + pImm[k];
         KAdd:  mRf[pRd[k]] = mRf[pRs1[k]] + mRf[pRs2[k]];
         KSub:  mRf[pRd[k]] = mRf[pRs1[k]] - mRf[pRs2[k]];
         KAnd:  mRf[pRd[k]] = mRf[pRs1[k]] & mRf[pRs2[k]];
         KOr:   mRf[pRd[k]] = mRf[pRs1[k]] | mRf[pRs2[k]];
         KXor:  mRf[pRd[k]] = mRf[pRs1[k]] ^ mRf[pRs2[k]];
         KLui:  mRf[pRd[k]] = pImm[k];
         KLw:   mRf[pRd[k]] = dImg[a[11:2]];   // base is 4 KB aligned
         KSw: begin
            if (a >= `RRV_CR_BASE) begin
               mLed = mRf[pRs2[k]][7:0];
            end else begin
               dImg[a[11:2]] = mRf[pRs2[k]];
            end
         end
         KBeq: begin
            if (mRf[pRs1[k]] == mRf[pRs2[k]]) begin
               pc = pc - 32'd4 + pImm[k];
            end
         end
         KBne: begin
            if (mRf[pRs1[k]] != mRf[pRs2[k]]) begin
               pc = pc - 32'd4 + pImm[k];
            end
         end
         default: begin
            mRf[pRd[k]] = pc;                  // link
            pc          = pc - 32'd4 + pImm[k];
         end
      endcase
      mRf[0] = '0;                             // x0 stays zero
      k      = int'(pc >> 2);
   end
endtask

// ==============================
// compare tasks
// ==============================
task automatic checkWord(input string name, input tWord expVal, input tWord actVal);
   if (actVal !== expVal) begin
      errWord++;
      $display("ERROR %s: expected %h, actual %h", name, expVal, actVal);
   end
endtask

task automatic checkLed(input string name, input logic [7:0] expVal, input logic [7:0] actVal);
   if (actVal !== expVal) begin
      errLed++;
      $display("ERROR %s: expected %h, actual %h", name, expVal, actVal);
   end
endtask

// ==============================
// fabric tasks
// ==============================
task automatic fabricStep(input logic vld, input tFabOp op, input tAddr addr, input tWord data,
                          output logic acc);
   int lat;
   @(negedge Clock);
   inFabricValidQ503H   = vld;
   inFabricOpQ503H      = op;
   inFabricAddressQ503H = addr;
   inFabricDataQ503H    = data;
   fpgaIn               = swDrive;
   fabReady             = !bpOn || rnd(4) != 0;   // about one cycle in four held off
   #1;                                             // coreRrvReady follows fabReady
   acc = vld && coreRrvReady;
   stepCount++;
   if (outFabricValidQ505H && !fabReady && coreRrvReady) begin
      errOther++;
      $display("%s: coreRrvReady stayed high while a response was held", curTest);
   end
   if (outFabricValidQ505H && fabReady) begin     // taken at the coming edge
      if (expQ.size() == 0) begin
         errOther++;
         $display("%s: a fabric response came back with no read outstanding", curTest);
      end else begin
         rdSeen++;
         lat = stepCount - acceptStepQ.pop_front();
         if (!bpOn && lat != 2) begin
            errOther++;
            $display("%s: a read response came %0d cycles after its request instead of 2",
                     curTest, lat);
         end
         checkWord(curTest, expQ.pop_front(), outFabricDataQ505H);
      end
   end
endtask

task automatic fabricRequest(input tFabOp op, input tAddr addr, input tWord data,
                             input tWord expVal);
   logic acc;
   acc = 1'b0;
   while (!acc) begin
      fabricStep(1'b1, op, addr, data, acc);
   end
   if (op == FabRead) begin
      expQ.push_back(expVal);
      acceptStepQ.push_back(stepCount);
      rdIssued++;
   end
endtask

task automatic drainFabric();
   logic acc;
   int   waited;
   waited = 0;
   while (expQ.size() != 0 && waited < 100) begin
      fabricStep(1'b0, FabRead, '0, '0, acc);
      waited++;
   end
   expQ.delete();                              // unanswered reads show in the closing count
   acceptStepQ.delete();
   repeat (4) begin
      fabricStep(1'b0, FabRead, '0, '0, acc);   // duplicates would land here
   end
endtask

task automatic switchCheck();
   logic acc;
   swDrive = 8'(rnd(256));
   fabricStep(1'b0, FabRead, '0, '0, acc);     // meta flop
   fabricStep(1'b0, FabRead, '0, '0, acc);     // sync flop
   fabricRequest(FabRead, `RRV_CR_BASE + 32'd4, '0, {24'b0, swDrive});
endtask

`endif

//--- verif/tb_core_rrv.sv
`timescale 1ns/1ps
`include "rrv_defines.svh"

module tb_core_rrv;
   import rrv_pkg::*;

   localparam int ProgLen   = 67;              // two luis, body, self-loop
   localparam int Window    = 64;              // d_mem words in use
   localparam int FabricOps = 200;
   localparam int RunCycles = ProgLen * 8;     // worst case per instruction
   localparam int WatchdogCycles = RunCycles + (FabricOps + 2 * ProgLen + Window + 16) * 12 + 2000;

   logic       Clock = 1'b0;
   logic       arstN;
   logic       RstPc;
   logic       inFabricValidQ503H;
   tFabOp      inFabricOpQ503H;
   tAddr       inFabricAddressQ503H;
   tWord       inFabricDataQ503H;
   logic       coreRrvReady;
   logic       outFabricValidQ505H;
   tWord       outFabricDataQ505H;
   logic       fabReady;
   logic [7:0] fpgaIn;
   logic [7:0] fpgaOut;

   int         seed = 32'ha6de;
   int         errWord = 0;
   int         errLed = 0;
   int         errOther = 0;
   int         rdIssued = 0;
   int         rdSeen = 0;
   int         stepCount = 0;
   logic       bpOn = 1'b0;                    // random fabReady drops
   logic [7:0] swDrive = 8'h00;
   string      curTest = "fabric_rt";

   always #50 Clock = ~Clock;

   core_rrv_top i_dut (
      .Clock(Clock), .arstN(arstN), .RstPc(RstPc),
      .inFabricValidQ503H(inFabricValidQ503H), .inFabricOpQ503H(inFabricOpQ503H),
      .inFabricAddressQ503H(inFabricAddressQ503H), .inFabricDataQ503H(inFabricDataQ503H),
      .coreRrvReady(coreRrvReady), .outFabricValidQ505H(outFabricValidQ505H),
      .outFabricDataQ505H(outFabricDataQ505H), .fabReady(fabReady),
      .fpgaIn(fpgaIn), .fpgaOut(fpgaOut)
   );

`include "tb_rrv_model.svh"

   task automatic printCounts();
      $display("errors: word %0d, led %0d, other %0d", errWord, errLed, errOther);
   endtask

   initial begin
      #(WatchdogCycles * 100);
      $display("run timed out after %0d cycles in test %s", WatchdogCycles, curTest);
      printCounts();
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int unsigned k;
      tWord        d;
      int          start;
      logic [7:0]  led;
      arstN                = 1'b0;
      RstPc                = 1'b1;             // core parked while loading
      inFabricValidQ503H   = 1'b0;
      inFabricOpQ503H      = FabRead;
      inFabricAddressQ503H = '0;
      inFabricDataQ503H    = '0;
      fabReady             = 1'b1;
      fpgaIn               = 8'h00;
      repeat (3) @(negedge Clock);
      if (coreRrvReady !== 1'b1 || outFabricValidQ505H !== 1'b0) begin
         errOther++;
         $display("fabric port is not idle after reset");
      end
      arstN = 1'b1;

      // ==============================
      // fabric round trip to d_mem
      // ==============================
      for (int n = 0; n < FabricOps; n++) begin
         if (n == FabricOps / 2) begin
            drainFabric();
            curTest = "backpressure";
            bpOn    = 1'b1;
         end
         k = rnd(Window);
         d = $random(seed);
         if (rnd(3) == 0) begin
            dImg[k] = d;
            fabricRequest(FabWrite, `RRV_DMEM_BASE + 4 * k, d, '0);
         end else begin
            fabricRequest(FabRead, `RRV_DMEM_BASE + 4 * k, '0, dImg[k]);
         end
      end
      drainFabric();

      // ==============================
      // program load and run
      // ==============================
      curTest = "imem_load";
      bpOn    = 1'b0;
      genProgram();
      runModel();
      for (int p = 0; p < ProgLen; p++) begin
         fabricRequest(FabWrite, `RRV_IMEM_BASE + 4 * p, encode(p), '0);
      end
      for (int p = 0; p < ProgLen; p++) begin
         fabricRequest(FabRead, `RRV_IMEM_BASE + 4 * p, '0, encode(p));
      end
      drainFabric();
      @(negedge Clock);
      RstPc   = 1'b0;                          // fetch from reset pc
      curTest = "cr_switch";
      bpOn    = 1'b1;
      start   = stepCount;
      while (stepCount - start < RunCycles) begin
         switchCheck();                        // cr reads collide with led stores
      end
      drainFabric();
      checkLed("cr_core_led", mLed, fpgaOut);

      curTest = "dmem_image";
      for (int w = 0; w < Window; w++) begin
         fabricRequest(FabRead, `RRV_DMEM_BASE + 4 * w, '0, dImg[w]);
      end
      drainFabric();

      // fabric write after the program overrides the led
      curTest = "cr_fabric_led";
      led     = 8'(rnd(256));
      fabricRequest(FabWrite, `RRV_CR_BASE, {24'b0, led}, '0);
      fabricRequest(FabRead, `RRV_CR_BASE, '0, {24'b0, led});
      drainFabric();
      checkLed("cr_fabric_led", led, fpgaOut);

      if (rdSeen != rdIssued) begin
         errOther++;
         $display("fabric returned %0d read responses for %0d reads", rdSeen, rdIssued);
      end
      printCounts();
      if (errWord + errLed + errOther == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+source
+incdir+verif
source/rrv_pkg.sv
source/rrv_dpram.sv
source/rrv_cr_regs.sv
source/core_rrv.sv
source/core_rrv_mem_wrap.sv
source/core_rrv_top.sv
verif/tb_core_rrv.sv

//--- Makefile
SIM = obj_dir/Vtb_core_rrv

$(SIM): all.f $(wildcard source/*.sv source/*.svh verif/*.sv verif/*.svh)
	verilator --binary --timing --assert -j 0 --top-module tb_core_rrv -f all.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: run clean
